// ==== include/ctrl_cfg.svh ====
`ifndef CTRL_CFG_SVH
`define CTRL_CFG_SVH

// instruction word and retire tag
`define CTRL_INSTR_W    32
`define CTRL_TAG_W      8
`define CTRL_OP_W       4

// queue depth is 1 << CTRL_FIFO_AW
`define CTRL_FIFO_AW    2

// per-stage cycle count fields
`define CTRL_CNT_W      4
`define CTRL_LOAD_LSB   8
`define CTRL_EXEC_LSB   12
`define CTRL_STORE_LSB  16
`define CTRL_OP_LSB     28

`endif

// ==== hw/ctrl_pkg.sv ====
`default_nettype none
`include "ctrl_cfg.svh"

package ctrl_pkg;

  // one instruction as it sits in a queue
  typedef logic [`CTRL_INSTR_W-1:0] instr_t;

  // unknown codes decode as nop
  typedef enum logic [`CTRL_OP_W-1:0] {
    OP_NOP = 4'h0,
    OP_RUN = 4'h1
  } opcode_e;

  typedef enum logic [1:0] {
    ST_IDLE    = 2'd0,
    ST_RUN     = 2'd1,
    ST_HANDOFF = 2'd2
  } stage_state_e;

endpackage

`default_nettype wire

// ==== hw/instr_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "ctrl_cfg.svh"

module instr_fifo
  import ctrl_pkg::*;
(
  input  wire                      clk,
  input  wire                      i_rst_n,
  input  wire                      i_wr_en,
  input  wire  [`CTRL_INSTR_W-1:0] i_wr_data,
  input  wire                      i_rd_en,
  output logic [`CTRL_INSTR_W-1:0] o_rd_data,
  output logic                     o_empty,
  output logic                     o_full
);

  localparam int DEPTH = 1 << `CTRL_FIFO_AW;

  instr_t                  mem [DEPTH];
  logic [`CTRL_FIFO_AW-1:0] wr_ptr;
  logic [`CTRL_FIFO_AW-1:0] rd_ptr;
  logic [`CTRL_FIFO_AW:0]   count;
  logic                    do_wr;
  logic                    do_rd;

  assign do_wr = i_wr_en && !o_full;
  assign do_rd = i_rd_en && !o_empty;

  // count reaches DEPTH only when the top bit is set
  assign o_empty   = (count == '0);
  assign o_full    = count[`CTRL_FIFO_AW];
  assign o_rd_data = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (do_wr) begin
      mem[wr_ptr] <= i_wr_data;
    end
  end

  // pointers wrap on their own width
  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr) wr_ptr <= wr_ptr + 1'b1;
      if (do_rd) rd_ptr <= rd_ptr + 1'b1;
      case ({do_wr, do_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // writers and readers must watch the flags
  a_no_wr_full: assert property (@(posedge clk) disable iff (!i_rst_n)
    i_wr_en |-> !o_full);
  a_no_rd_empty: assert property (@(posedge clk) disable iff (!i_rst_n)
    i_rd_en |-> !o_empty);

endmodule

`default_nettype wire

// ==== hw/stage_control.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "ctrl_cfg.svh"

module stage_control
  import ctrl_pkg::*;
#(
  parameter int CNT_LSB = `CTRL_LOAD_LSB
) (
  input  wire                      clk,
  input  wire                      i_rst_n,
  // upstream queue
  input  wire                      i_in_empty,
  input  wire  [`CTRL_INSTR_W-1:0] i_in_data,
  output logic                     o_in_rd_en,
  // downstream queue
  input  wire                      i_out_full,
  output logic                     o_out_wr_en,
  output logic [`CTRL_INSTR_W-1:0] o_out_data,
  // datapath side
  input  wire                      i_hold,
  output logic                     o_strobe,
  output logic                     o_idle
);

  stage_state_e           state_q;
  stage_state_e           state_d;
  instr_t                 instr_q;
  logic [`CTRL_CNT_W-1:0] cnt_q;
  logic [`CTRL_CNT_W-1:0] in_cnt;
  opcode_e                op;
  logic                   is_run;

  // count field of the word at the queue head
  assign in_cnt = i_in_data[CNT_LSB +: `CTRL_CNT_W];

  assign op     = opcode_e'(instr_q[`CTRL_OP_LSB +: `CTRL_OP_W]);
  assign is_run = (op == OP_RUN);

  ////////////////////////////////////////
  // queue handshakes
  ////////////////////////////////////////

  assign o_in_rd_en  = (state_q == ST_IDLE) && !i_in_empty;
  assign o_out_wr_en = (state_q == ST_HANDOFF) && !i_out_full && !i_hold;
  assign o_out_data  = instr_q;

  // strobe is low while held so the count stays exact
  assign o_strobe = (state_q == ST_RUN) && is_run && !i_hold;
  assign o_idle   = (state_q == ST_IDLE);

  ////////////////////////////////////////
  // fsm
  ////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: begin
        if (!i_in_empty) begin
          // zero count skips the run phase
          state_d = (in_cnt == '0) ? ST_HANDOFF : ST_RUN;
        end
      end
      ST_RUN: begin
        if (!i_hold && (cnt_q == 'd1)) begin
          state_d = ST_HANDOFF;
        end
      end
      ST_HANDOFF: begin
        if (o_out_wr_en) begin
          state_d = ST_IDLE;
        end
      end
      default: begin
        state_d = ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      state_q <= ST_IDLE;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      if (o_in_rd_en) begin
        cnt_q <= in_cnt;
      end else if ((state_q == ST_RUN) && !i_hold) begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

  // instruction register
  always_ff @(posedge clk) begin
    if (o_in_rd_en) begin
      instr_q <= i_in_data;
    end
  end

  // strobe only while cycles remain in the run phase
  a_strobe_in_run: assert property (@(posedge clk) disable iff (!i_rst_n)
    o_strobe |-> (state_q == ST_RUN) && (cnt_q != '0));

endmodule

`default_nettype wire

// ==== hw/control_unit.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "ctrl_cfg.svh"

module control_unit (
  input  wire                      clk,
  input  wire                      i_rst_n,
  // instruction writer
  input  wire                      i_instr_wr_en,
  input  wire  [`CTRL_INSTR_W-1:0] i_instr_data,
  output logic                     o_instr_full,
  // store side back-pressure
  input  wire                      i_store_stall,
  // datapath strobes
  output logic                     o_load_en,
  output logic                     o_execute_en,
  output logic                     o_store_en,
  // retire port
  output logic                     o_retire_valid,
  output logic [`CTRL_TAG_W-1:0]   o_retire_tag,
  output logic                     o_idle
);

  logic                     cmd_wr_en;
  logic                     cmd_rd_en;
  logic                     cmd_empty;
  logic                     cmd_full;
  logic [`CTRL_INSTR_W-1:0] cmd_data;

  logic                     exec_wr_en;
  logic                     exec_rd_en;
  logic                     exec_empty;
  logic                     exec_full;
  logic [`CTRL_INSTR_W-1:0] exec_in_data;
  logic [`CTRL_INSTR_W-1:0] exec_data;

  logic                     store_wr_en;
  logic                     store_rd_en;
  logic                     store_empty;
  logic                     store_full;
  logic [`CTRL_INSTR_W-1:0] store_in_data;
  logic [`CTRL_INSTR_W-1:0] store_data;
  logic [`CTRL_INSTR_W-1:0] retire_data;

  logic                     load_idle;
  logic                     execute_idle;
  logic                     store_idle;

  // writes into a full queue are dropped here
  assign cmd_wr_en    = i_instr_wr_en && !cmd_full;
  assign o_instr_full = cmd_full;

  assign o_retire_tag = retire_data[`CTRL_TAG_W-1:0];
  assign o_idle       = load_idle && execute_idle && store_idle &&
                        cmd_empty && exec_empty && store_empty;

  ////////////////////////////////////////
  // load
  ////////////////////////////////////////

  instr_fifo cmd_fifo (
    .clk(clk), .i_rst_n(i_rst_n),
    .i_wr_en(cmd_wr_en), .i_wr_data(i_instr_data),
    .i_rd_en(cmd_rd_en), .o_rd_data(cmd_data),
    .o_empty(cmd_empty), .o_full(cmd_full)
  );

  stage_control #(.CNT_LSB(`CTRL_LOAD_LSB)) load_stage (
    .clk(clk), .i_rst_n(i_rst_n),
    .i_in_empty(cmd_empty), .i_in_data(cmd_data), .o_in_rd_en(cmd_rd_en),
    .i_out_full(exec_full), .o_out_wr_en(exec_wr_en), .o_out_data(exec_in_data),
    .i_hold(1'b0), .o_strobe(o_load_en), .o_idle(load_idle)
  );

  ////////////////////////////////////////
  // execute
  ////////////////////////////////////////

  instr_fifo exec_fifo (
    .clk(clk), .i_rst_n(i_rst_n),
    .i_wr_en(exec_wr_en), .i_wr_data(exec_in_data),
    .i_rd_en(exec_rd_en), .o_rd_data(exec_data),
    .o_empty(exec_empty), .o_full(exec_full)
  );

  stage_control #(.CNT_LSB(`CTRL_EXEC_LSB)) execute_stage (
    .clk(clk), .i_rst_n(i_rst_n),
    .i_in_empty(exec_empty), .i_in_data(exec_data), .o_in_rd_en(exec_rd_en),
    .i_out_full(store_full), .o_out_wr_en(store_wr_en), .o_out_data(store_in_data),
    .i_hold(1'b0), .o_strobe(o_execute_en), .o_idle(execute_idle)
  );

  ////////////////////////////////////////
  // store and retire
  ////////////////////////////////////////

  instr_fifo store_fifo (
    .clk(clk), .i_rst_n(i_rst_n),
    .i_wr_en(store_wr_en), .i_wr_data(store_in_data),
    .i_rd_en(store_rd_en), .o_rd_data(store_data),
    .o_empty(store_empty), .o_full(store_full)
  );

  // retire never back-pressures, only the stall does
  stage_control #(.CNT_LSB(`CTRL_STORE_LSB)) store_stage (
    .clk(clk), .i_rst_n(i_rst_n),
    .i_in_empty(store_empty), .i_in_data(store_data), .o_in_rd_en(store_rd_en),
    .i_out_full(1'b0), .o_out_wr_en(o_retire_valid), .o_out_data(retire_data),
    .i_hold(i_store_stall), .o_strobe(o_store_en), .o_idle(store_idle)
  );

endmodule

`default_nettype wire

// ==== tb/control_unit_tb.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "ctrl_cfg.svh"

module control_unit_tb
  import ctrl_pkg::*;
();

  logic                     clk;
  logic                     i_rst_n;
  logic                     i_instr_wr_en;
  logic [`CTRL_INSTR_W-1:0] i_instr_data;
  logic                     i_store_stall;
  logic                     o_instr_full;
  logic                     o_load_en;
  logic                     o_execute_en;
  logic                     o_store_en;
  logic                     o_retire_valid;
  logic [`CTRL_TAG_W-1:0]   o_retire_tag;
  logic                     o_idle;

  // stimulus lines from the data file
  byte unsigned             line_kind [$];
  logic [`CTRL_INSTR_W-1:0] line_word [$];
  int                       line_num  [$];

  // reference model state
  logic [`CTRL_TAG_W-1:0] exp_tags [$];
  int exp_load, exp_exec, exp_store;
  int got_load, got_exec, got_store;
  int rejected;
  int num_writes, total_stall, stall_left;
  int cycles, cycle_limit;
  bit saw_full;

  control_unit DUT (
    .clk(clk), .i_rst_n(i_rst_n),
    .i_instr_wr_en(i_instr_wr_en), .i_instr_data(i_instr_data),
    .o_instr_full(o_instr_full), .i_store_stall(i_store_stall),
    .o_load_en(o_load_en), .o_execute_en(o_execute_en), .o_store_en(o_store_en),
    .o_retire_valid(o_retire_valid), .o_retire_tag(o_retire_tag), .o_idle(o_idle)
  );

  initial clk = 1'b0;
  always #50 clk = ~clk;

  task automatic fail_now(input string what);
    $display("%s", what);
    $display("Checks failed");
    $fatal(1, "run stopped");
  endtask

  function automatic int field_value(input logic [`CTRL_INSTR_W-1:0] w, input int lsb);
    return int'(w[lsb +: `CTRL_CNT_W]);
  endfunction

  // only the run opcode raises strobes, everything else acts as nop
  function automatic bit raises_strobes(input logic [`CTRL_INSTR_W-1:0] w);
    return w[`CTRL_OP_LSB +: `CTRL_OP_W] == OP_RUN;
  endfunction

  ////////////////////////////////////////
  // cycle limit and output monitor
  ////////////////////////////////////////

  always @(posedge clk) begin
    cycles++;
    if (cycle_limit > 0 && cycles >= cycle_limit) begin
      fail_now($sformatf("timeout: run did not finish within %0d cycles", cycle_limit));
    end
  end

  always @(posedge clk) begin
    if (i_rst_n) begin
      if (o_instr_full) saw_full = 1'b1;
      if (i_instr_wr_en && o_instr_full) begin
        rejected++;
      end else if (i_instr_wr_en) begin
        exp_tags.push_back(i_instr_data[`CTRL_TAG_W-1:0]);
        if (raises_strobes(i_instr_data)) begin
          exp_load  += field_value(i_instr_data, `CTRL_LOAD_LSB);
          exp_exec  += field_value(i_instr_data, `CTRL_EXEC_LSB);
          exp_store += field_value(i_instr_data, `CTRL_STORE_LSB);
        end
      end
      if (i_store_stall) begin
        assert (!o_store_en && !o_retire_valid)
          else fail_now("store strobe or retire seen while the store side was stalled");
      end
      if (o_retire_valid) begin
        assert (exp_tags.size() != 0) else fail_now("a tag retired with no write outstanding");
        assert (o_retire_tag == exp_tags[0])
          else fail_now($sformatf("mismatch at %0d ns: retire tag %02h, expected %02h",
                                  $time, o_retire_tag, exp_tags[0]));
        void'(exp_tags.pop_front());
      end
      if (o_load_en) got_load++;
      if (o_execute_en) got_exec++;
      if (o_store_en) got_store++;
    end
  end

  ////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////

  task automatic next_cycle();
    @(posedge clk);
    i_instr_wr_en <= 1'b0;
    if (stall_left > 0) begin
      i_store_stall <= 1'b1;
      stall_left--;
    end else begin
      i_store_stall <= 1'b0;
    end
  endtask

  task automatic write_instr(input logic [`CTRL_INSTR_W-1:0] word, input int idle);
    int gap;
    gap = idle + int'($urandom % 4);
    repeat (gap) next_cycle();
    next_cycle();
    i_instr_wr_en <= 1'b1;
    i_instr_data  <= word;
  endtask

  initial begin
    int                       fd;
    string                    line;
    logic [`CTRL_INSTR_W-1:0] word;
    int                       num;
    i_rst_n       = 1'b0;
    i_instr_wr_en = 1'b0;
    i_instr_data  = '0;
    i_store_stall = 1'b0;
    void'($urandom(72));
    fd = $fopen("tb/control_unit_testdata.txt", "r");
    assert (fd != 0) else fail_now("cannot open tb/control_unit_testdata.txt");
    // comment lines match neither pattern and are skipped
    while (!$feof(fd)) begin
      void'($fgets(line, fd));
      if ($sscanf(line, "W %h %d", word, num) == 2) begin
        line_kind.push_back("W");
        line_word.push_back(word);
        line_num.push_back(num);
        num_writes++;
      end else if ($sscanf(line, "S %d", num) == 1) begin
        line_kind.push_back("S");
        line_word.push_back('0);
        line_num.push_back(num);
        total_stall += num;
      end
    end
    $fclose(fd);
    cycle_limit = 40 * num_writes + total_stall + 200;

    repeat (2) next_cycle();
    i_rst_n <= 1'b1;
    next_cycle();
    assert (!o_load_en && !o_execute_en && !o_store_en && !o_retire_valid && o_idle)
      else fail_now("outputs were not at rest right after reset");

    foreach (line_kind[i]) begin
      if (line_kind[i] == "W") write_instr(line_word[i], line_num[i]);
      else stall_left = line_num[i];
    end
    next_cycle();
    while (exp_tags.size() != 0 || stall_left != 0) next_cycle();
    next_cycle();

    assert (o_idle) else fail_now("o_idle stayed low after every tag retired");
    assert (got_load == exp_load)
      else fail_now($sformatf("mismatch at %0d ns: load strobe %0d cycles, expected %0d",
                              $time, got_load, exp_load));
    assert (got_exec == exp_exec)
      else fail_now($sformatf("mismatch at %0d ns: execute strobe %0d cycles, expected %0d",
                              $time, got_exec, exp_exec));
    assert (got_store == exp_store)
      else fail_now($sformatf("mismatch at %0d ns: store strobe %0d cycles, expected %0d",
                              $time, got_store, exp_store));
    assert (saw_full && rejected > 0)
      else fail_now("the long stall never filled the queues or turned a write away");
    $display("All checks passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb/control_unit_testdata.txt ====
# W <instr hex> <idle cycles>: op[31:28] store[19:16] exec[15:12] load[11:8] tag[7:0]
# S <cycles>: hold i_store_stall high for that many cycles
W 10023101 0
W 00045602 2
W 10000003 1
W 70012104 0
W 1001f005 3
S 100
W 10011010 0
W 10010111 0
W 10020012 0
W 00010113 0
W 10011014 0
W 10001115 0
W 10012016 0
W 90010117 0
W 10011018 0
W 10010019 0
W 1002101a 0
W 1001001b 0
W 1001111c 0
W 1003001d 0
W 1001101e 0
W 1002011f 0

// ==== tb.f ====
+incdir+include
hw/ctrl_pkg.sv
hw/instr_fifo.sv
hw/stage_control.sv
hw/control_unit.sv
tb/control_unit_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the control unit testbench with Verilator and run it.
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  -f tb.f \
  --top-module control_unit_tb \
  --Mdir obj_dir \
  -o control_unit_sim
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

output="$(./obj_dir/control_unit_sim)"
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -Fxq "All checks passed"; then
  exit 0
fi
echo "pass message not found in simulation output"
exit 1
